// ==== vlog.f ====
+incdir+include
rtl/cam_pkg.sv
rtl/fifo_if.sv
rtl/byte_fifo.sv
rtl/cmd_ctrl.sv
rtl/reply_framer.sv
rtl/pwm_bank.sv
rtl/cam_ctrl_top.sv
tb/tb_cam_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run with verilator, result taken from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_cam_ctrl -o tb_cam_ctrl > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_cam_ctrl > sim.log 2>&1
cat sim.log

grep -q "^Simulation completed successfully$" sim.log \
   && { echo "result: pass"; exit 0; } \
   || { echo "result: fail"; exit 1; }

// ==== include/cam_tb_tasks.svh ====
`ifndef CAM_TB_TASKS_SVH
`define CAM_TB_TASKS_SVH

// a missed wait counts as an error and cuts short all later waits
task automatic note_timeout(input string what);
   errors++;
   timed_out = 1'b1;
   $display("[%0t] timeout while waiting for %s", $time, what);
endtask

// one byte into the receive fifo, once it has room
task automatic send_byte(input logic [7:0] b);
   int waited;
   waited = 0;
   while (!timed_out) begin
      @(negedge clk);
      if (!rx_full) break;
      waited++;
      if (waited >= WAIT_LIMIT) note_timeout("room in the receive FIFO");
   end
   if (!timed_out) begin
      @(posedge clk);
      rx_data <= b;
      rx_wr   <= 1'b1;
      @(posedge clk);
      rx_wr   <= 1'b0;
   end
endtask

// head byte of the transmit fifo, then pop it
task automatic pop_tx_byte(output logic [7:0] b);
   int waited;
   waited = 0;
   b      = 8'h00;
   while (!timed_out) begin
      @(negedge clk);
      if (!tx_empty) break;
      waited++;
      if (waited >= WAIT_LIMIT) note_timeout("a byte in the transmit FIFO");
   end
   if (!timed_out) begin
      b = tx_data;   // fall through, valid before the pop
      @(posedge clk);
      tx_rd <= 1'b1;
      @(posedge clk);
      tx_rd <= 1'b0;
   end
endtask

task automatic read_reply(output reply_e kind, output logic [7:0] idx,
                          output logic [7:0] val);
   logic [7:0] hdr;
   pop_tx_byte(hdr);
   pop_tx_byte(idx);
   pop_tx_byte(val);
   kind = reply_e'(hdr);
endtask

// high cycles over one full pwm period
task automatic measure_duty(input int which, output int high);
   high = 0;
   repeat (256) begin
      @(negedge clk);
      case (which)
         PWM_P1:  high += int'(pwm_peltier_1);
         PWM_P2:  high += int'(pwm_peltier_2);
         default: high += int'(pwm_shutter);
      endcase
   end
endtask

task automatic check_byte(input string name, input logic [7:0] got,
                          input logic [7:0] exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %02h expected %02h", $time, name, got, exp);
   end
endtask

task automatic check_reply(input string name, input reply_e got, input reply_e exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %02h expected %02h", $time, name, got, exp);
   end
endtask

task automatic check_duty(input string name, input int got, input logic [7:0] exp);
   checks++;
   if (got != int'(exp)) begin
      errors++;
      $display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
   end
endtask

`endif

// ==== tb/tb_cam_ctrl.sv ====
`default_nettype none

module tb_cam_ctrl
   import cam_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT  = 2000;  // cycles per wait
   localparam int PWM_P1      = 0;
   localparam int PWM_P2      = 1;
   localparam int PWM_SHUTTER = 2;

   logic       clk;
   logic       rst_n;
   logic [7:0] rx_data;
   logic       rx_wr;
   logic       rx_full;
   logic [7:0] tx_data;
   logic       tx_rd;
   logic       tx_empty;
   logic       pwm_peltier_1;
   logic       pwm_peltier_2;
   logic       pwm_shutter;

   int         errors;
   int         checks;
   logic       timed_out;
   logic [7:0] exp_regs [NUM_REGS];  // expected settings registers

   cam_ctrl_top #(
      .RX_ADDR_W (3),
      .TX_ADDR_W (4)
   ) uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .rx_data       (rx_data),
      .rx_wr         (rx_wr),
      .rx_full       (rx_full),
      .tx_data       (tx_data),
      .tx_rd         (tx_rd),
      .tx_empty      (tx_empty),
      .pwm_peltier_1 (pwm_peltier_1),
      .pwm_peltier_2 (pwm_peltier_2),
      .pwm_shutter   (pwm_shutter)
   );

   always #4 clk = ~clk;  // 8 ns period

   `include "cam_tb_tasks.svh"

   task automatic set_reg(input logic [7:0] idx, input logic [7:0] val);
      send_byte(CMD_SET_REG);
      send_byte(idx);
      send_byte(val);
      if (int'(idx) < NUM_REGS) begin
         exp_regs[int'(idx)] = val;  // out of range writes are dropped
      end
   endtask

   task automatic check_reg_reply(input logic [7:0] idx, input reply_e kind,
                                  input logic [7:0] ridx, input logic [7:0] rval);
      if (int'(idx) < NUM_REGS) begin
         check_reply("tx_data header", kind, REPLY_REG);
         check_byte("tx_data value", rval, exp_regs[int'(idx)]);
      end else begin
         check_reply("tx_data header", kind, REPLY_BAD_INDEX);
         check_byte("tx_data value", rval, 8'h00);
      end
      check_byte("tx_data index", ridx, idx);
   endtask

   // replies come back in order, so this also marks earlier commands done
   task automatic get_and_check(input logic [7:0] idx);
      reply_e     kind;
      logic [7:0] ridx;
      logic [7:0] rval;
      send_byte(CMD_GET_REG);
      send_byte(idx);
      read_reply(kind, ridx, rval);
      check_reg_reply(idx, kind, ridx, rval);
   endtask

   task automatic check_all_duties(input logic [7:0] shutter_exp);
      int duty;
      measure_duty(PWM_P1, duty);
      check_duty("pwm_peltier_1 duty", duty, exp_regs[0]);
      measure_duty(PWM_P2, duty);
      check_duty("pwm_peltier_2 duty", duty, exp_regs[1]);
      measure_duty(PWM_SHUTTER, duty);
      check_duty("pwm_shutter duty", duty, shutter_exp);
   endtask

   task automatic report_test(input string name, input int start);
      if (errors == start) begin
         $display("[%0t] %s: ok", $time, name);
      end else begin
         $display("[%0t] %s: %0d errors", $time, name, errors - start);
      end
   endtask

   task automatic verify_reset_state();
      int start;
      start = errors;
      @(negedge clk);
      check_byte("tx_empty", {7'b0, tx_empty}, 8'h01);
      check_byte("rx_full", {7'b0, rx_full}, 8'h00);
      check_all_duties(8'h96);
      report_test("reset_state", start);
   endtask

   task automatic write_and_measure();
      int         start;
      logic [7:0] v0;
      logic [7:0] v1;
      start = errors;
      v0    = 8'($urandom);
      v1    = 8'($urandom);
      set_reg(8'd0, v0);
      set_reg(8'd1, v1);
      set_reg(8'd4, ~v0);  // out of range index
      get_and_check(8'd1);
      check_all_duties(8'h96);
      report_test("reg_writes", start);
   endtask

   task automatic read_back_regs();
      int start;
      start = errors;
      set_reg(8'd2, 8'($urandom));
      get_and_check(8'd0);
      get_and_check(8'd1);
      get_and_check(8'd2);
      get_and_check(8'd3);  // bad index
      report_test("reg_reads", start);
   endtask

   task automatic toggle_shutter();
      int start;
      start = errors;
      send_byte(CMD_OPEN_SHUTTER);
      get_and_check(8'd2);
      check_all_duties(8'h50);
      send_byte(8'h7e);  // unknown opcodes
      send_byte(8'h00);
      get_and_check(8'd0);
      get_and_check(8'd1);
      check_all_duties(8'h50);
      send_byte(CMD_CLOSE_SHUTTER);
      get_and_check(8'd2);
      check_all_duties(8'h96);
      report_test("shutter", start);
   endtask

   // 11 requests: 5 replies and a header fill the tx fifo, one request
   // waits in the controller and 8 bytes fill the rx fifo
   task automatic fill_tx_fifo();
      int         start;
      logic [7:0] idx_q [$];
      reply_e     kind;
      logic [7:0] ridx;
      logic [7:0] rval;
      start = errors;
      for (int i = 0; i < 11; i++) begin
         send_byte(CMD_GET_REG);
         send_byte(8'(i % 4));
         idx_q.push_back(8'(i % 4));
      end
      repeat (4) @(negedge clk);
      check_byte("rx_full", {7'b0, rx_full}, 8'h01);
      check_byte("tx_empty", {7'b0, tx_empty}, 8'h00);
      while (idx_q.size() > 0) begin
         read_reply(kind, ridx, rval);
         check_reg_reply(idx_q.pop_front(), kind, ridx, rval);
      end
      @(negedge clk);
      check_byte("tx_empty", {7'b0, tx_empty}, 8'h01);
      check_byte("rx_full", {7'b0, rx_full}, 8'h00);
      report_test("backpressure", start);
   endtask

   task automatic reset_by_command();
      int start;
      start = errors;
      set_reg(8'd0, 8'($urandom) | 8'h01);
      set_reg(8'd1, 8'($urandom) | 8'h01);
      set_reg(8'd2, 8'($urandom) | 8'h01);
      send_byte(CMD_OPEN_SHUTTER);
      send_byte(CMD_RESET);
      for (int i = 0; i < NUM_REGS; i++) begin
         exp_regs[i] = 8'h00;
      end
      get_and_check(8'd0);
      get_and_check(8'd1);
      get_and_check(8'd2);
      check_all_duties(8'h96);
      report_test("cmd_reset", start);
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      rx_data   = 8'h00;
      rx_wr     = 1'b0;
      tx_rd     = 1'b0;
      errors    = 0;
      checks    = 0;
      timed_out = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
         exp_regs[i] = 8'h00;
      end
      void'($urandom(32'h165d));

      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);  // let the pwm outputs settle

      verify_reset_state();
      write_and_measure();
      read_back_regs();
      toggle_shutter();
      fill_tx_fifo();
      reset_by_command();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/cam_ctrl_top.sv ====
`default_nettype none

module cam_ctrl_top
   import cam_pkg::*;
#(
   parameter int RX_ADDR_W = 3,
   parameter int TX_ADDR_W = 4
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] rx_data,
   input  logic       rx_wr,
   output logic       rx_full,
   output logic [7:0] tx_data,
   input  logic       tx_rd,
   output logic       tx_empty,
   output logic       pwm_peltier_1,
   output logic       pwm_peltier_2,
   output logic       pwm_shutter
);
   fifo_if rx_if ();
   fifo_if tx_if ();

   logic        reply_start;
   reply_e      reply_kind;
   logic [15:0] reply_word;
   logic        framer_busy;
   logic [7:0]  peltier_1_duty;
   logic [7:0]  peltier_2_duty;
   logic        shutter_open;

   // host side of both fifos
   assign rx_if.wdata = rx_data;
   assign rx_if.winc  = rx_wr;
   assign rx_full     = rx_if.wfull;
   assign tx_if.rinc  = tx_rd;
   assign tx_data     = tx_if.rdata;
   assign tx_empty    = tx_if.rempty;

   byte_fifo #(.ADDR_W(RX_ADDR_W)) rx_fifo (.clk(clk), .rst_n(rst_n), .f(rx_if.buffer));

   byte_fifo #(.ADDR_W(TX_ADDR_W)) tx_fifo (.clk(clk), .rst_n(rst_n), .f(tx_if.buffer));

   cmd_ctrl u_cmd_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .rx             (rx_if.reader),
      .reply_start    (reply_start),
      .reply_kind     (reply_kind),
      .reply_word     (reply_word),
      .framer_busy    (framer_busy),
      .peltier_1_duty (peltier_1_duty),
      .peltier_2_duty (peltier_2_duty),
      .shutter_open   (shutter_open)
   );

   reply_framer u_reply_framer (
      .clk         (clk),
      .rst_n       (rst_n),
      .reply_start (reply_start),
      .reply_kind  (reply_kind),
      .reply_word  (reply_word),
      .framer_busy (framer_busy),
      .tx          (tx_if.writer)
   );

   pwm_bank u_pwm_bank (
      .clk            (clk),
      .rst_n          (rst_n),
      .peltier_1_duty (peltier_1_duty),
      .peltier_2_duty (peltier_2_duty),
      .shutter_open   (shutter_open),
      .pwm_peltier_1  (pwm_peltier_1),
      .pwm_peltier_2  (pwm_peltier_2),
      .pwm_shutter    (pwm_shutter)
   );

endmodule

`default_nettype wire

// ==== rtl/pwm_bank.sv ====
`default_nettype none

module pwm_bank
   import cam_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] peltier_1_duty,
   input  logic [7:0] peltier_2_duty,
   input  logic       shutter_open,
   output logic       pwm_peltier_1,
   output logic       pwm_peltier_2,
   output logic       pwm_shutter
);
   logic [7:0] cnt;           // free running, period 256
   logic [7:0] shutter_duty;

   assign shutter_duty = shutter_open ? SHUTTER_OPEN_DUTY : SHUTTER_CLOSED_DUTY;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= 8'h00;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // registered outputs, so no compare glitches reach the pins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pwm_peltier_1 <= 1'b0;
         pwm_peltier_2 <= 1'b0;
         pwm_shutter   <= 1'b0;
      end else begin
         pwm_peltier_1 <= (cnt < peltier_1_duty);
         pwm_peltier_2 <= (cnt < peltier_2_duty);
         pwm_shutter   <= (cnt < shutter_duty);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/reply_framer.sv ====
`default_nettype none

module reply_framer
   import cam_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        reply_start,
   input  reply_e      reply_kind,
   input  logic [15:0] reply_word,
   output logic        framer_busy,
   fifo_if.writer      tx
);
   framer_state_e state;
   reply_e        kind_q;
   logic [15:0]   word_q;   // index high, value low

   assign framer_busy = (state != F_IDLE);
   assign tx.winc     = framer_busy && !tx.wfull;

   always_comb begin
      case (state)
         F_HDR:   tx.wdata = kind_q;
         F_MSB:   tx.wdata = word_q[15:8];
         F_LSB:   tx.wdata = word_q[7:0];
         default: tx.wdata = 8'h00;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= F_IDLE;
         kind_q <= REPLY_REG;
         word_q <= 16'h0000;
      end else begin
         case (state)
            F_IDLE: begin
               if (reply_start) begin
                  kind_q <= reply_kind;
                  word_q <= reply_word;
                  state  <= F_HDR;
               end
            end
            // each byte holds until the fifo has room
            F_HDR: begin
               if (!tx.wfull) begin
                  state <= F_MSB;
               end
            end
            F_MSB: begin
               if (!tx.wfull) begin
                  state <= F_LSB;
               end
            end
            F_LSB: begin
               if (!tx.wfull) begin
                  state <= F_IDLE;  // last byte written
               end
            end
            default: state <= F_IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      reply_start |-> state == F_IDLE)
      else $error("reply_start while a reply is in flight");

endmodule

`default_nettype wire

// ==== rtl/cmd_ctrl.sv ====
`default_nettype none

module cmd_ctrl
   import cam_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   fifo_if.reader      rx,
   output logic        reply_start,
   output reply_e      reply_kind,
   output logic [15:0] reply_word,
   input  logic        framer_busy,
   output logic [7:0]  peltier_1_duty,
   output logic [7:0]  peltier_2_duty,
   output logic        shutter_open
);
   localparam int IDX_W = $clog2(NUM_REGS);

   ctrl_state_e state;
   cmd_e        cmd;     // opcode under execution
   logic [7:0]  idx;
   logic [7:0]  val;
   logic [7:0]  regs [NUM_REGS];
   logic        idx_ok;

   assign idx_ok = (idx < 8'(NUM_REGS));

   assign peltier_1_duty = regs[0];
   assign peltier_2_duty = regs[1];

   // pop in the first cycle a byte is waiting
   always_comb begin
      case (state)
         IDLE, WAIT_IDX, WAIT_VAL: rx.rinc = !rx.rempty;
         default:                  rx.rinc = 1'b0;
      endcase
   end

   assign reply_start = (state == SEND) && !framer_busy;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= IDLE;
         cmd          <= cmd_e'(8'h00);
         idx          <= 8'h00;
         val          <= 8'h00;
         reply_kind   <= REPLY_REG;
         reply_word   <= 16'h0000;
         shutter_open <= 1'b0;
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= 8'h00;
         end
      end else begin
         case (state)
            IDLE: begin
               if (!rx.rempty) begin
                  cmd   <= cmd_e'(rx.rdata);
                  state <= EVAL;
               end
            end

            EVAL: begin
               case (cmd)
                  CMD_SET_REG, CMD_GET_REG: state <= WAIT_IDX;
                  CMD_OPEN_SHUTTER: begin
                     shutter_open <= 1'b1;
                     state        <= IDLE;
                  end
                  CMD_CLOSE_SHUTTER: begin
                     shutter_open <= 1'b0;
                     state        <= IDLE;
                  end
                  CMD_RESET: begin
                     for (int i = 0; i < NUM_REGS; i++) begin
                        regs[i] <= 8'h00;
                     end
                     shutter_open <= 1'b0;
                     state        <= IDLE;
                  end
                  default: state <= IDLE;  // unknown byte, no arguments
               endcase
            end

            WAIT_IDX: begin
               if (!rx.rempty) begin
                  idx <= rx.rdata;
                  if (cmd == CMD_SET_REG) begin
                     state <= WAIT_VAL;
                  end else begin
                     state <= EXEC;
                  end
               end
            end

            WAIT_VAL: begin
               if (!rx.rempty) begin
                  val   <= rx.rdata;
                  state <= EXEC;
               end
            end

            EXEC: begin
               if (cmd == CMD_SET_REG) begin
                  if (idx_ok) begin
                     regs[idx[IDX_W-1:0]] <= val;
                  end
                  state <= IDLE;
               end else begin
                  // register read, answer goes to the framer
                  if (idx_ok) begin
                     reply_kind <= REPLY_REG;
                     reply_word <= {idx, regs[idx[IDX_W-1:0]]};
                  end else begin
                     reply_kind <= REPLY_BAD_INDEX;
                     reply_word <= {idx, 8'h00};
                  end
                  state <= SEND;
               end
            end

            SEND: begin
               if (!framer_busy) begin
                  state <= IDLE;
               end
            end

            default: state <= IDLE;
         endcase
      end
   end

   // framer takes every request and reports busy on the next edge
   assert property (@(posedge clk) disable iff (!rst_n)
      reply_start |=> framer_busy)
      else $error("framer did not take reply_start");

endmodule

`default_nettype wire

// ==== rtl/byte_fifo.sv ====
`default_nettype none

module byte_fifo #(
   parameter int ADDR_W = 3
) (
   input logic    clk,
   input logic    rst_n,
   fifo_if.buffer f
);
   localparam int DEPTH = 2 ** ADDR_W;

   logic [7:0]        mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [ADDR_W:0]   count;  // one extra bit to tell full from empty
   logic              do_wr;
   logic              do_rd;

   assign do_wr = f.winc && !f.wfull;
   assign do_rd = f.rinc && !f.rempty;

   assign f.wfull  = (count == (ADDR_W + 1)'(DEPTH));
   assign f.rempty = (count == '0);
   assign f.rdata  = mem[rd_ptr]; // first word fall through

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= f.wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   // writer and reader must respect the levels
   assert property (@(posedge clk) disable iff (!rst_n)
      f.winc |-> !f.wfull)
      else $error("byte_fifo overflow, write while full");

   assert property (@(posedge clk) disable iff (!rst_n)
      f.rinc |-> !f.rempty)
      else $error("byte_fifo underflow, read while empty");

endmodule

`default_nettype wire

// ==== rtl/fifo_if.sv ====
`default_nettype none

interface fifo_if;
   logic [7:0] wdata;
   logic       winc;
   logic       wfull;
   logic [7:0] rdata;   // head byte, valid while rempty is low
   logic       rempty;
   logic       rinc;

   modport buffer (
      input  wdata, winc, rinc,
      output wfull, rdata, rempty
   );

   modport writer (
      output wdata, winc,
      input  wfull
   );

   modport reader (
      output rinc,
      input  rdata, rempty
   );
endinterface

`default_nettype wire

// ==== rtl/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

   // host command opcodes, first byte of every command
   typedef enum logic [7:0] {
      CMD_SET_REG       = 8'h01, // index, value
      CMD_GET_REG       = 8'h02, // index
      CMD_OPEN_SHUTTER  = 8'h03,
      CMD_CLOSE_SHUTTER = 8'h04,
      CMD_RESET         = 8'h05  // clears settings, closes shutter
   } cmd_e;

   // reply header, followed by index byte and value byte
   typedef enum logic [7:0] {
      REPLY_REG       = 8'hA2,
      REPLY_BAD_INDEX = 8'hAE
   } reply_e;

   typedef enum logic [2:0] {
      IDLE,
      EVAL,
      WAIT_IDX,
      WAIT_VAL,
      EXEC,
      SEND
   } ctrl_state_e;

   typedef enum logic [1:0] {
      F_IDLE,
      F_HDR,
      F_MSB,
      F_LSB
   } framer_state_e;

   // 0 peltier 1 duty, 1 peltier 2 duty, 2 spare mode
   localparam int NUM_REGS = 3;

   // servo duty out of 256
   localparam logic [7:0] SHUTTER_OPEN_DUTY   = 8'h50;
   localparam logic [7:0] SHUTTER_CLOSED_DUTY = 8'h96;

endpackage

`default_nettype wire
